//--- commit_pkg.sv
/*
 * shared widths, functional-unit and operation enums and the
 * op classification helpers of the retire stage
 */
`default_nettype none

package commit_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CAUSE_W    = 6;
  // accrued fp flags ride in the low cause bits
  localparam int unsigned FFLAGS_W   = 5;
  localparam int unsigned TRANS_ID_W = 3;
  // program counter width
  localparam int unsigned VLEN       = 32;

  // functional unit of a scoreboard entry
  typedef enum logic [2:0] {
    NONE,
    ALU,
    LOAD,
    STORE,
    CTRL_FLOW,
    MULT,
    CSR,
    FPU
  } fu_t;

  // operation subset seen at retire
  typedef enum logic [4:0] {
    // ADD doubles as the csr no-op
    ADD,
    CSR_WRITE,
    CSR_READ,
    CSR_SET,
    CSR_CLEAR,
    FENCE,
    FENCE_I,
    AMO_SWAP,
    AMO_ADD,
    AMO_LR,
    AMO_SC,
    FADD,
    FMUL,
    FLD,
    // fp ops with an integer destination
    FCMP,
    FMV_X,
    OTHER
  } fu_op_t;

  // atomic memory operations
  function automatic logic is_amo(input fu_op_t op);
    return op inside {AMO_SWAP, AMO_ADD, AMO_LR, AMO_SC};
  endfunction

  // ops whose destination lives in the fp register file
  function automatic logic is_rd_fpr(input fu_op_t op);
    return op inside {FADD, FMUL, FLD};
  endfunction

endpackage

`default_nettype wire

//--- commit_port0.sv
/*
 * port-0 retire logic: ack, writeback, lsu / csr / fence / amo strobes
 * and the fflags and fp-dirty terms handed to the second port
 */
`timescale 1ns/1ps
`default_nettype none

module commit_port0 #(
  parameter int unsigned XLEN = 32
) (
  // oldest scoreboard entry
  input  wire logic                         instr0_valid_i,
  input  wire commit_pkg::fu_t              instr0_fu_i,
  input  wire commit_pkg::fu_op_t           instr0_op_i,
  input  wire logic [XLEN-1:0]              instr0_result_i,
  input  wire logic                         instr0_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0] instr0_ex_cause_i,
  // controller and cache levels
  input  wire logic                         halt_i,
  input  wire logic                         flush_dcache_i,
  input  wire logic                         single_step_i,
  input  wire logic                         commit_lsu_ready_i,
  input  wire logic                         no_st_pending_i,
  input  wire logic                         amo_ack_i,
  input  wire logic [XLEN-1:0]              amo_result_i,
  input  wire logic [XLEN-1:0]              csr_rdata_i,
  input  wire logic                         csr_ex_valid_i,
  // retire and writeback
  output logic                              ack0_o,
  output logic                              we_gpr0_o,
  output logic                              we_fpr0_o,
  output logic [XLEN-1:0]                   wdata0_o,
  // side effects
  output logic                              commit_lsu_o,
  output logic                              commit_csr_o,
  output commit_pkg::fu_op_t                csr_op_o,
  output logic [XLEN-1:0]                   csr_wdata0_o,
  output logic                              fence_o,
  output logic                              fence_i_o,
  output logic                              amo_valid_commit_o,
  output logic                              flush_commit_o,
  // terms merged by port 1
  output logic                              fflags0_wr_o,
  output logic [commit_pkg::FFLAGS_W-1:0]   fflags0_o,
  output logic                              fp_dirty0_o,
  output logic                              pair_ok_o
);

  import commit_pkg::*;

  logic instr0_is_amo;
  logic instr0_is_fpr;

  assign instr0_is_amo = is_amo(instr0_op_i);
  assign instr0_is_fpr = is_rd_fpr(instr0_op_i);

  // flags of a retiring fp op sit in the low cause bits
  assign fflags0_o = instr0_ex_cause_i[FFLAGS_W-1:0];

  always_comb begin
    ack0_o             = 1'b0;
    we_gpr0_o          = 1'b0;
    we_fpr0_o          = 1'b0;
    // amo result takes the port while the cache answers
    wdata0_o           = (instr0_is_amo && amo_ack_i) ? amo_result_i : instr0_result_i;
    commit_lsu_o       = 1'b0;
    commit_csr_o       = 1'b0;
    // csr no-op
    csr_op_o           = ADD;
    csr_wdata0_o       = '0;
    fence_o            = 1'b0;
    fence_i_o          = 1'b0;
    amo_valid_commit_o = 1'b0;
    flush_commit_o     = 1'b0;
    fflags0_wr_o       = 1'b0;

    // faulting entries and halt requests never retire
    if (instr0_valid_i && !instr0_ex_valid_i && !halt_i) begin
      ack0_o = 1'b1;
      if (instr0_is_fpr) begin
        we_fpr0_o = 1'b1;
      end else begin
        we_gpr0_o = 1'b1;
      end

      // ----------------------------------------------------------------------
      // store commit
      // ----------------------------------------------------------------------
      // stall while the store buffer is full
      if (instr0_fu_i == STORE && !instr0_is_amo) begin
        ack0_o       = commit_lsu_ready_i;
        commit_lsu_o = commit_lsu_ready_i;
      end

      // accrued fp flags
      if (instr0_fu_i == FPU) begin
        csr_wdata0_o = {{(XLEN-FFLAGS_W){1'b0}}, fflags0_o};
        fflags0_wr_o = 1'b1;
        ack0_o       = 1'b1;
      end

      // ----------------------------------------------------------------------
      // csr commit
      // ----------------------------------------------------------------------
      if (instr0_fu_i == CSR) begin
        csr_op_o     = instr0_op_i;
        csr_wdata0_o = instr0_result_i;
        if (!csr_ex_valid_i) begin
          commit_csr_o = 1'b1;
          // old csr value goes to rd
          wdata0_o     = csr_rdata_i;
          ack0_o       = 1'b1;
        end else begin
          ack0_o    = 1'b0;
          we_gpr0_o = 1'b0;
        end
      end

      // ----------------------------------------------------------------------
      // fences
      // ----------------------------------------------------------------------
      // a d$ flush request is served like fence.i on a write-back cache
      if (instr0_op_i == FENCE_I || (flush_dcache_i && instr0_fu_i != STORE)) begin
        ack0_o    = no_st_pending_i;
        fence_i_o = no_st_pending_i;
      end
      // drain the store buffer before flushing the d$
      if (instr0_op_i == FENCE) begin
        ack0_o  = no_st_pending_i;
        fence_o = no_st_pending_i;
      end

      // ----------------------------------------------------------------------
      // amo
      // ----------------------------------------------------------------------
      // held until the response, then the pipeline is flushed
      if (instr0_is_amo) begin
        amo_valid_commit_o = 1'b1;
        ack0_o             = amo_ack_i;
        flush_commit_o     = amo_ack_i;
        we_gpr0_o          = amo_ack_i;
      end
    end
  end

  // any acked fp work marks the f state dirty
  assign fp_dirty0_o = ack0_o & ((instr0_fu_i == FPU) | instr0_is_fpr);

  // second retire only behind a plain port-0 op outside single step
  assign pair_ok_o = ack0_o & (instr0_fu_i != CSR) & ~instr0_is_amo
                   & ~flush_dcache_i & ~single_step_i;

endmodule

`default_nettype wire

//--- commit_exception.sv
/*
 * exception select: earlier entry exception over csr exception,
 * masked by halt
 */
`timescale 1ns/1ps
`default_nettype none

module commit_exception #(
  parameter int unsigned XLEN = 32
) (
  input  wire logic                           instr0_valid_i,
  input  wire logic                           instr0_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0] instr0_ex_cause_i,
  input  wire logic [XLEN-1:0]                instr0_ex_tval_i,
  input  wire logic                           csr_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0] csr_ex_cause_i,
  input  wire logic                           halt_i,
  output logic                                ex_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]      ex_cause_o,
  output logic [XLEN-1:0]                     ex_tval_o
);

  always_comb begin
    ex_valid_o = 1'b0;
    ex_cause_o = '0;
    ex_tval_o  = '0;
    // only a valid entry can trap
    if (instr0_valid_i) begin
      // csr trap keeps the entry tval, which holds the instruction bits
      if (csr_ex_valid_i) begin
        ex_valid_o = 1'b1;
        ex_cause_o = csr_ex_cause_i;
        ex_tval_o  = instr0_ex_tval_i;
      end
      // earlier faults (e.g. page faults) win
      if (instr0_ex_valid_i) begin
        ex_valid_o = 1'b1;
        ex_cause_o = instr0_ex_cause_i;
        ex_tval_o  = instr0_ex_tval_i;
      end
    end
    // no trap is taken while halted
    if (halt_i) begin
      ex_valid_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- commit_port1.sv
/*
 * second commit port: retire decision and writeback, plus the fflags,
 * csr write data and fp-dirty merge over both ports
 */
`timescale 1ns/1ps
`default_nettype none

module commit_port1 #(
  parameter int unsigned XLEN = 32
) (
  // second-oldest scoreboard entry
  input  wire logic                           instr1_valid_i,
  input  wire commit_pkg::fu_t                instr1_fu_i,
  input  wire commit_pkg::fu_op_t             instr1_op_i,
  input  wire logic [XLEN-1:0]                instr1_result_i,
  input  wire logic                           instr1_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0] instr1_ex_cause_i,
  // from port 0 and the exception select
  input  wire logic                           pair_ok_i,
  input  wire logic                           ex_valid_i,
  input  wire logic                           fflags0_wr_i,
  input  wire logic [commit_pkg::FFLAGS_W-1:0] fflags0_i,
  input  wire logic [XLEN-1:0]                csr_wdata0_i,
  input  wire logic                           fp_dirty0_i,
  // retire and writeback
  output logic                                ack1_o,
  output logic                                we_gpr1_o,
  output logic                                we_fpr1_o,
  output logic [XLEN-1:0]                     wdata1_o,
  // merged csr side
  output logic [XLEN-1:0]                     csr_wdata_o,
  output logic                                csr_write_fflags_o,
  output logic                                dirty_fp_state_o
);

  import commit_pkg::*;

  logic                instr1_is_fpr;
  logic                fu1_ok;
  logic                fpu1_ack;
  logic [FFLAGS_W-1:0] fflags1;
  logic [FFLAGS_W-1:0] fflags_merged;

  assign instr1_is_fpr = is_rd_fpr(instr1_op_i);
  assign fflags1       = instr1_ex_cause_i[FFLAGS_W-1:0];

  // only units without side effects may retire second
  assign fu1_ok = instr1_fu_i inside {ALU, LOAD, CTRL_FLOW, MULT, FPU};

  // ------------------------------------------------------------------------
  // retire decision
  // ------------------------------------------------------------------------
  assign ack1_o    = pair_ok_i & instr1_valid_i & ~ex_valid_i & ~instr1_ex_valid_i & fu1_ok;
  assign we_fpr1_o = ack1_o & instr1_is_fpr;
  assign we_gpr1_o = ack1_o & ~instr1_is_fpr;
  assign wdata1_o  = instr1_result_i;

  // ------------------------------------------------------------------------
  // fflags merge
  // ------------------------------------------------------------------------
  assign fpu1_ack = ack1_o & (instr1_fu_i == FPU);

  // both ports raise flags in the same cycle, so none may be lost
  assign fflags_merged = fflags0_wr_i ? (fflags0_i | fflags1) : fflags1;

  assign csr_wdata_o = fpu1_ack ? {{(XLEN-FFLAGS_W){1'b0}}, fflags_merged} : csr_wdata0_i;

  assign csr_write_fflags_o = fflags0_wr_i | fpu1_ack;

  // f state goes dirty on either port
  assign dirty_fp_state_o = fp_dirty0_i | fpu1_ack | (ack1_o & instr1_is_fpr);

endmodule

`default_nettype wire

//--- commit_stage.sv
/*
 * dual-port retire stage top: port-0 logic, exception select and
 * second-port unit wired to the scoreboard and csr interfaces
 */
`timescale 1ns/1ps
`default_nettype none

module commit_stage #(
  parameter int unsigned XLEN = 32
) (
  // scoreboard entry 0
  input  wire logic                              instr0_valid_i,
  input  wire commit_pkg::fu_t                   instr0_fu_i,
  input  wire commit_pkg::fu_op_t                instr0_op_i,
  input  wire logic [commit_pkg::REG_ADDR_W-1:0] instr0_rd_i,
  input  wire logic [XLEN-1:0]                   instr0_result_i,
  input  wire logic                              instr0_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0]    instr0_ex_cause_i,
  input  wire logic [XLEN-1:0]                   instr0_ex_tval_i,
  input  wire logic [commit_pkg::TRANS_ID_W-1:0] instr0_trans_id_i,
  input  wire logic [commit_pkg::VLEN-1:0]       instr0_pc_i,
  // scoreboard entry 1
  input  wire logic                              instr1_valid_i,
  input  wire commit_pkg::fu_t                   instr1_fu_i,
  input  wire commit_pkg::fu_op_t                instr1_op_i,
  input  wire logic [commit_pkg::REG_ADDR_W-1:0] instr1_rd_i,
  input  wire logic [XLEN-1:0]                   instr1_result_i,
  input  wire logic                              instr1_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0]    instr1_ex_cause_i,
  input  wire logic [XLEN-1:0]                   instr1_ex_tval_i,
  // controller, cache and csr levels
  input  wire logic                              halt_i,
  input  wire logic                              flush_dcache_i,
  input  wire logic                              single_step_i,
  input  wire logic                              commit_lsu_ready_i,
  input  wire logic                              no_st_pending_i,
  input  wire logic                              amo_ack_i,
  input  wire logic [XLEN-1:0]                   amo_result_i,
  input  wire logic [XLEN-1:0]                   csr_rdata_i,
  input  wire logic                              csr_ex_valid_i,
  input  wire logic [commit_pkg::CAUSE_W-1:0]    csr_ex_cause_i,
  // retire and register file writeback
  output logic [1:0]                             commit_ack_o,
  output logic [1:0]                             we_gpr_o,
  output logic [1:0]                             we_fpr_o,
  output logic [1:0][XLEN-1:0]                   wdata_o,
  output logic [1:0][commit_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic [commit_pkg::TRANS_ID_W-1:0]      commit_tran_id_o,
  output logic [commit_pkg::VLEN-1:0]            pc_o,
  // selected exception
  output logic                                   ex_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]         ex_cause_o,
  output logic [XLEN-1:0]                        ex_tval_o,
  // csr file
  output commit_pkg::fu_op_t                     csr_op_o,
  output logic [XLEN-1:0]                        csr_wdata_o,
  output logic                                   csr_write_fflags_o,
  output logic                                   commit_csr_o,
  output logic                                   dirty_fp_state_o,
  // lsu and controller strobes
  output logic                                   commit_lsu_o,
  output logic                                   amo_valid_commit_o,
  output logic                                   fence_o,
  output logic                                   fence_i_o,
  output logic                                   flush_commit_o
);

  import commit_pkg::*;

  // port 0 to port 1
  logic                pair_ok;
  logic                fflags0_wr;
  logic [FFLAGS_W-1:0] fflags0;
  logic [XLEN-1:0]     csr_wdata0;
  logic                fp_dirty0;

  // straight pass-through of the head entry
  assign waddr_o[0]       = instr0_rd_i;
  assign waddr_o[1]       = instr1_rd_i;
  assign pc_o             = instr0_pc_i;
  assign commit_tran_id_o = instr0_trans_id_i;

  // ------------------------------------------------------------------------
  // port 0
  // ------------------------------------------------------------------------
  commit_port0 #(
    .XLEN(XLEN)
  ) commit_port0_i (
    .instr0_valid_i     (instr0_valid_i),
    .instr0_fu_i        (instr0_fu_i),
    .instr0_op_i        (instr0_op_i),
    .instr0_result_i    (instr0_result_i),
    .instr0_ex_valid_i  (instr0_ex_valid_i),
    .instr0_ex_cause_i  (instr0_ex_cause_i),
    .halt_i             (halt_i),
    .flush_dcache_i     (flush_dcache_i),
    .single_step_i      (single_step_i),
    .commit_lsu_ready_i (commit_lsu_ready_i),
    .no_st_pending_i    (no_st_pending_i),
    .amo_ack_i          (amo_ack_i),
    .amo_result_i       (amo_result_i),
    .csr_rdata_i        (csr_rdata_i),
    .csr_ex_valid_i     (csr_ex_valid_i),
    .ack0_o             (commit_ack_o[0]),
    .we_gpr0_o          (we_gpr_o[0]),
    .we_fpr0_o          (we_fpr_o[0]),
    .wdata0_o           (wdata_o[0]),
    .commit_lsu_o       (commit_lsu_o),
    .commit_csr_o       (commit_csr_o),
    .csr_op_o           (csr_op_o),
    .csr_wdata0_o       (csr_wdata0),
    .fence_o            (fence_o),
    .fence_i_o          (fence_i_o),
    .amo_valid_commit_o (amo_valid_commit_o),
    .flush_commit_o     (flush_commit_o),
    .fflags0_wr_o       (fflags0_wr),
    .fflags0_o          (fflags0),
    .fp_dirty0_o        (fp_dirty0),
    .pair_ok_o          (pair_ok)
  );

  // exception select runs beside port 0
  commit_exception #(
    .XLEN(XLEN)
  ) commit_exception_i (
    .instr0_valid_i    (instr0_valid_i),
    .instr0_ex_valid_i (instr0_ex_valid_i),
    .instr0_ex_cause_i (instr0_ex_cause_i),
    .instr0_ex_tval_i  (instr0_ex_tval_i),
    .csr_ex_valid_i    (csr_ex_valid_i),
    .csr_ex_cause_i    (csr_ex_cause_i),
    .halt_i            (halt_i),
    .ex_valid_o        (ex_valid_o),
    .ex_cause_o        (ex_cause_o),
    .ex_tval_o         (ex_tval_o)
  );

  // ------------------------------------------------------------------------
  // port 1 and merge
  // ------------------------------------------------------------------------
  commit_port1 #(
    .XLEN(XLEN)
  ) commit_port1_i (
    .instr1_valid_i     (instr1_valid_i),
    .instr1_fu_i        (instr1_fu_i),
    .instr1_op_i        (instr1_op_i),
    .instr1_result_i    (instr1_result_i),
    .instr1_ex_valid_i  (instr1_ex_valid_i),
    .instr1_ex_cause_i  (instr1_ex_cause_i),
    .pair_ok_i          (pair_ok),
    .ex_valid_i         (ex_valid_o),
    .fflags0_wr_i       (fflags0_wr),
    .fflags0_i          (fflags0),
    .csr_wdata0_i       (csr_wdata0),
    .fp_dirty0_i        (fp_dirty0),
    .ack1_o             (commit_ack_o[1]),
    .we_gpr1_o          (we_gpr_o[1]),
    .we_fpr1_o          (we_fpr_o[1]),
    .wdata1_o           (wdata_o[1]),
    .csr_wdata_o        (csr_wdata_o),
    .csr_write_fflags_o (csr_write_fflags_o),
    .dirty_fp_state_o   (dirty_fp_state_o)
  );

endmodule

`default_nettype wire

//--- tb_commit_stage.sv
/*
 * random-stimulus testbench for the dual-port retire stage with a
 * reference model and a falling-edge compare process
 */
`timescale 1ns/1ps
`default_nettype none

module tb_commit_stage;

  import commit_pkg::*;

  localparam int unsigned XLEN           = 32;
  localparam int unsigned NUM_VECTORS    = 2000;
  // vectors plus reset and some slack
  localparam int unsigned TIMEOUT_CYCLES = 2100;
  localparam logic [31:0] SEED           = 32'h0b74_fb2d;

  // ------------------------------------------------------------------------
  // expected response of one input set
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [1:0]            ack;
    logic [1:0]            we_gpr;
    logic [1:0]            we_fpr;
    logic [XLEN-1:0]       wdata0;
    logic [XLEN-1:0]       wdata1;
    logic [REG_ADDR_W-1:0] waddr0;
    logic [REG_ADDR_W-1:0] waddr1;
    logic [TRANS_ID_W-1:0] tran_id;
    logic [VLEN-1:0]       pc;
    logic                  ex_valid;
    logic [CAUSE_W-1:0]    ex_cause;
    logic [XLEN-1:0]       ex_tval;
    fu_op_t                csr_op;
    logic [XLEN-1:0]       csr_wdata;
    logic                  write_fflags;
    logic                  commit_csr;
    logic                  dirty_fp;
    logic                  commit_lsu;
    logic                  amo_commit;
    logic                  fence;
    logic                  fence_i;
    logic                  flush;
  } expected_t;

  logic clk_i = 1'b0;
  logic rst_n_i;

  // scoreboard entries
  logic                  instr0_valid, instr1_valid;
  fu_t                   instr0_fu, instr1_fu;
  fu_op_t                instr0_op, instr1_op;
  logic [REG_ADDR_W-1:0] instr0_rd, instr1_rd;
  logic [XLEN-1:0]       instr0_result, instr1_result;
  logic                  instr0_ex_valid, instr1_ex_valid;
  logic [CAUSE_W-1:0]    instr0_ex_cause, instr1_ex_cause;
  logic [XLEN-1:0]       instr0_ex_tval, instr1_ex_tval;
  logic [TRANS_ID_W-1:0] instr0_trans_id;
  logic [VLEN-1:0]       instr0_pc;
  // environment levels
  logic                  halt, flush_dcache, single_step;
  logic                  commit_lsu_ready, no_st_pending, amo_ack;
  logic [XLEN-1:0]       amo_result, csr_rdata;
  logic                  csr_ex_valid;
  logic [CAUSE_W-1:0]    csr_ex_cause;

  // dut responses
  logic [1:0]                  commit_ack, we_gpr, we_fpr;
  logic [1:0][XLEN-1:0]        wdata;
  logic [1:0][REG_ADDR_W-1:0]  waddr;
  logic [TRANS_ID_W-1:0]       commit_tran_id;
  logic [VLEN-1:0]             pc;
  logic                        ex_valid;
  logic [CAUSE_W-1:0]          ex_cause;
  logic [XLEN-1:0]             ex_tval;
  fu_op_t                      csr_op;
  logic [XLEN-1:0]             csr_wdata;
  logic                        csr_write_fflags, commit_csr, dirty_fp_state;
  logic                        commit_lsu, amo_valid_commit, fence, fence_i, flush_commit;

  logic [31:0] rng_state = SEED;
  int unsigned vec_cnt   = 0;
  int unsigned cycle_cnt = 0;
  expected_t   exp_q;

  commit_stage #(
    .XLEN(XLEN)
  ) commit_stage_i (
    .instr0_valid_i     (instr0_valid),
    .instr0_fu_i        (instr0_fu),
    .instr0_op_i        (instr0_op),
    .instr0_rd_i        (instr0_rd),
    .instr0_result_i    (instr0_result),
    .instr0_ex_valid_i  (instr0_ex_valid),
    .instr0_ex_cause_i  (instr0_ex_cause),
    .instr0_ex_tval_i   (instr0_ex_tval),
    .instr0_trans_id_i  (instr0_trans_id),
    .instr0_pc_i        (instr0_pc),
    .instr1_valid_i     (instr1_valid),
    .instr1_fu_i        (instr1_fu),
    .instr1_op_i        (instr1_op),
    .instr1_rd_i        (instr1_rd),
    .instr1_result_i    (instr1_result),
    .instr1_ex_valid_i  (instr1_ex_valid),
    .instr1_ex_cause_i  (instr1_ex_cause),
    .instr1_ex_tval_i   (instr1_ex_tval),
    .halt_i             (halt),
    .flush_dcache_i     (flush_dcache),
    .single_step_i      (single_step),
    .commit_lsu_ready_i (commit_lsu_ready),
    .no_st_pending_i    (no_st_pending),
    .amo_ack_i          (amo_ack),
    .amo_result_i       (amo_result),
    .csr_rdata_i        (csr_rdata),
    .csr_ex_valid_i     (csr_ex_valid),
    .csr_ex_cause_i     (csr_ex_cause),
    .commit_ack_o       (commit_ack),
    .we_gpr_o           (we_gpr),
    .we_fpr_o           (we_fpr),
    .wdata_o            (wdata),
    .waddr_o            (waddr),
    .commit_tran_id_o   (commit_tran_id),
    .pc_o               (pc),
    .ex_valid_o         (ex_valid),
    .ex_cause_o         (ex_cause),
    .ex_tval_o          (ex_tval),
    .csr_op_o           (csr_op),
    .csr_wdata_o        (csr_wdata),
    .csr_write_fflags_o (csr_write_fflags),
    .commit_csr_o       (commit_csr),
    .dirty_fp_state_o   (dirty_fp_state),
    .commit_lsu_o       (commit_lsu),
    .amo_valid_commit_o (amo_valid_commit),
    .fence_o            (fence),
    .fence_i_o          (fence_i),
    .flush_commit_o     (flush_commit)
  );

  // 40 ns clock
  always #20 clk_i = ~clk_i;

  // xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  function automatic expected_t ref_model();
    expected_t           e;
    logic                amo0;
    logic                fpr0;
    logic                fpr1;
    logic                fflags0_wr;
    logic                dirty0;
    logic                pair_ok;
    logic                fpu1;
    logic [FFLAGS_W-1:0] flags0;
    logic [FFLAGS_W-1:0] flags1;
    logic [XLEN-1:0]     csr_wdata0;
    e          = '0;
    e.csr_op   = ADD;
    amo0       = instr0_op inside {AMO_SWAP, AMO_ADD, AMO_LR, AMO_SC};
    fpr0       = instr0_op inside {FADD, FMUL, FLD};
    fpr1       = instr1_op inside {FADD, FMUL, FLD};
    flags0     = instr0_ex_cause[FFLAGS_W-1:0];
    flags1     = instr1_ex_cause[FFLAGS_W-1:0];
    fflags0_wr = 1'b0;
    csr_wdata0 = '0;
    e.wdata0   = (amo0 && amo_ack) ? amo_result : instr0_result;
    e.wdata1   = instr1_result;
    e.waddr0   = instr0_rd;
    e.waddr1   = instr1_rd;
    e.tran_id  = instr0_trans_id;
    e.pc       = instr0_pc;
    // port 0, later rules override earlier ones
    if (instr0_valid && !instr0_ex_valid && !halt) begin
      e.ack[0]    = 1'b1;
      e.we_fpr[0] = fpr0;
      e.we_gpr[0] = !fpr0;
      if (instr0_fu == STORE && !amo0) begin
        e.ack[0]     = commit_lsu_ready;
        e.commit_lsu = commit_lsu_ready;
      end
      if (instr0_fu == FPU) begin
        fflags0_wr = 1'b1;
        csr_wdata0 = {{(XLEN-FFLAGS_W){1'b0}}, flags0};
        e.ack[0]   = 1'b1;
      end
      if (instr0_fu == CSR) begin
        e.csr_op   = instr0_op;
        csr_wdata0 = instr0_result;
        if (csr_ex_valid) begin
          e.ack[0]    = 1'b0;
          e.we_gpr[0] = 1'b0;
        end else begin
          e.commit_csr = 1'b1;
          e.wdata0     = csr_rdata;
          e.ack[0]     = 1'b1;
        end
      end
      // flush-d$ acts like fence.i
      if (instr0_op == FENCE_I || (flush_dcache && instr0_fu != STORE)) begin
        e.ack[0]  = no_st_pending;
        e.fence_i = no_st_pending;
      end
      if (instr0_op == FENCE) begin
        e.ack[0] = no_st_pending;
        e.fence  = no_st_pending;
      end
      if (amo0) begin
        e.amo_commit = 1'b1;
        e.ack[0]     = amo_ack;
        e.flush      = amo_ack;
        e.we_gpr[0]  = amo_ack;
      end
    end
    dirty0  = e.ack[0] && (instr0_fu == FPU || fpr0);
    pair_ok = e.ack[0] && instr0_fu != CSR && !amo0 && !flush_dcache && !single_step;
    // entry exception beats csr exception, halt masks the valid bit only
    if (instr0_valid && (instr0_ex_valid || csr_ex_valid)) begin
      e.ex_valid = 1'b1;
      e.ex_cause = instr0_ex_valid ? instr0_ex_cause : csr_ex_cause;
      e.ex_tval  = instr0_ex_tval;
    end
    e.ex_valid = e.ex_valid && !halt;
    // port 1
    e.ack[1] = pair_ok && instr1_valid && !e.ex_valid && !instr1_ex_valid
               && (instr1_fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU});
    e.we_fpr[1]    = e.ack[1] && fpr1;
    e.we_gpr[1]    = e.ack[1] && !fpr1;
    fpu1           = e.ack[1] && instr1_fu == FPU;
    e.write_fflags = fflags0_wr || fpu1;
    if (fpu1) begin
      e.csr_wdata = {{(XLEN-FFLAGS_W){1'b0}}, (fflags0_wr ? (flags0 | flags1) : flags1)};
    end else begin
      e.csr_wdata = csr_wdata0;
    end
    e.dirty_fp = dirty0 || fpu1 || (e.ack[1] && fpr1);
    return e;
  endfunction

  // mismatch ends the run
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] time %0t: %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // new random input set, biased toward valid entries and few traps
  task automatic drive_random();
    logic [31:0] r [0:9];
    for (int i = 0; i < 10; i++) begin
      rng_state = xorshift32(rng_state);
      r[i]      = rng_state;
    end
    instr0_valid     <= r[0][2:0] != 3'd0;
    instr0_fu        <= fu_t'(r[0][5:3]);
    instr0_op        <= fu_op_t'(5'(r[0][13:6] % 8'd17));
    instr0_rd        <= r[0][18:14];
    instr0_ex_valid  <= r[0][21:19] == 3'd0;
    instr0_ex_cause  <= r[0][27:22];
    instr0_trans_id  <= r[0][30:28];
    instr1_valid     <= r[1][2:0] != 3'd0;
    instr1_fu        <= fu_t'(r[1][5:3]);
    instr1_op        <= fu_op_t'(5'(r[1][13:6] % 8'd17));
    instr1_rd        <= r[1][18:14];
    instr1_ex_valid  <= r[1][21:19] == 3'd0;
    instr1_ex_cause  <= r[1][27:22];
    halt             <= r[2][3:0] == 4'd0;
    flush_dcache     <= r[2][7:4] == 4'd0;
    single_step      <= r[2][10:8] == 3'd0;
    commit_lsu_ready <= r[2][11];
    no_st_pending    <= r[2][13:12] != 2'd0;
    amo_ack          <= r[2][14];
    csr_ex_valid     <= r[2][17:15] == 3'd0;
    csr_ex_cause     <= r[2][23:18];
    instr0_result    <= r[3];
    instr1_result    <= r[4];
    amo_result       <= r[5];
    csr_rdata        <= r[6];
    instr0_pc        <= r[7];
    instr0_ex_tval   <= r[8];
    instr1_ex_tval   <= r[9];
  endtask

  // ------------------------------------------------------------------------
  // reset and stimulus
  // ------------------------------------------------------------------------
  initial begin
    rst_n_i          = 1'b0;
    instr0_valid     = 1'b0;
    instr0_fu        = NONE;
    instr0_op        = ADD;
    instr0_rd        = '0;
    instr0_result    = '0;
    instr0_ex_valid  = 1'b0;
    instr0_ex_cause  = '0;
    instr0_ex_tval   = '0;
    instr0_trans_id  = '0;
    instr0_pc        = '0;
    instr1_valid     = 1'b0;
    instr1_fu        = NONE;
    instr1_op        = ADD;
    instr1_rd        = '0;
    instr1_result    = '0;
    instr1_ex_valid  = 1'b0;
    instr1_ex_cause  = '0;
    instr1_ex_tval   = '0;
    halt             = 1'b0;
    flush_dcache     = 1'b0;
    single_step      = 1'b0;
    commit_lsu_ready = 1'b0;
    no_st_pending    = 1'b0;
    amo_ack          = 1'b0;
    amo_result       = '0;
    csr_rdata        = '0;
    csr_ex_valid     = 1'b0;
    csr_ex_cause     = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
  end

  always @(posedge clk_i) begin
    if (rst_n_i && vec_cnt < NUM_VECTORS) begin
      drive_random();
      vec_cnt <= vec_cnt + 1;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ------------------------------------------------------------------------
  // compare, half a cycle after the inputs settle
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_n_i && vec_cnt != 0) begin
      exp_q = ref_model();
      check_value("commit_ack", 64'(commit_ack), 64'(exp_q.ack));
      check_value("we_gpr", 64'(we_gpr), 64'(exp_q.we_gpr));
      check_value("we_fpr", 64'(we_fpr), 64'(exp_q.we_fpr));
      check_value("wdata[0]", 64'(wdata[0]), 64'(exp_q.wdata0));
      check_value("wdata[1]", 64'(wdata[1]), 64'(exp_q.wdata1));
      check_value("waddr[0]", 64'(waddr[0]), 64'(exp_q.waddr0));
      check_value("waddr[1]", 64'(waddr[1]), 64'(exp_q.waddr1));
      check_value("commit_tran_id", 64'(commit_tran_id), 64'(exp_q.tran_id));
      check_value("pc", 64'(pc), 64'(exp_q.pc));
      check_value("ex_valid", 64'(ex_valid), 64'(exp_q.ex_valid));
      check_value("ex_cause", 64'(ex_cause), 64'(exp_q.ex_cause));
      check_value("ex_tval", 64'(ex_tval), 64'(exp_q.ex_tval));
      check_value("csr_op", 64'(csr_op), 64'(exp_q.csr_op));
      check_value("csr_wdata", 64'(csr_wdata), 64'(exp_q.csr_wdata));
      check_value("csr_write_fflags", 64'(csr_write_fflags), 64'(exp_q.write_fflags));
      check_value("commit_csr", 64'(commit_csr), 64'(exp_q.commit_csr));
      check_value("dirty_fp_state", 64'(dirty_fp_state), 64'(exp_q.dirty_fp));
      check_value("commit_lsu", 64'(commit_lsu), 64'(exp_q.commit_lsu));
      check_value("amo_valid_commit", 64'(amo_valid_commit), 64'(exp_q.amo_commit));
      check_value("fence", 64'(fence), 64'(exp_q.fence));
      check_value("fence_i", 64'(fence_i), 64'(exp_q.fence_i));
      check_value("flush_commit", 64'(flush_commit), 64'(exp_q.flush));
      if (vec_cnt == NUM_VECTORS) begin
        $display("Simulation completed successfully");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- flist.f
commit_pkg.sv
commit_port0.sv
commit_exception.sv
commit_port1.sv
commit_stage.sv
tb_commit_stage.sv

//--- Makefile
# Verilator flow for the dual-port retire stage

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_commit_stage
RTL_TOP   ?= commit_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) \
	  -Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
